//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_tx_lane
FILELIST   := tx_lane.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_tx_lane.sv
`default_nettype none

module tb_tx_lane;

	timeunit 1ns;
	timeprecision 1ps;

	import tx_lane_pkg::*;

	localparam int NUM_TESTS = 10;

	typedef struct packed
	{
		logic        link_up;
		logic        rf_bypass;
		logic [1:0]  strobe_sel;    // 0 steady, 1 valid gaps, 2 enable gaps, 3 random
		logic [1:0]  header_sel;    // 0 data, 1 control, 2 random legal, 3 random any
		logic [15:0] block_count;
	} test_row_t;

	test_row_t test_table [NUM_TESTS] = '{
		'{1'b0, 1'b0, 2'd0, 2'd2, 16'd20},
		'{1'b0, 1'b0, 2'd3, 2'd3, 16'd12},
		'{1'b1, 1'b0, 2'd0, 2'd2, 16'd40},
		'{1'b1, 1'b0, 2'd1, 2'd0, 16'd30},
		'{1'b1, 1'b0, 2'd2, 2'd1, 16'd30},
		'{1'b1, 1'b0, 2'd0, 2'd3, 16'd40},
		'{1'b1, 1'b1, 2'd0, 2'd2, 16'd36},
		'{1'b1, 1'b1, 2'd3, 2'd2, 16'd20},
		'{1'b0, 1'b0, 2'd0, 2'd2, 16'd10},
		'{1'b1, 1'b0, 2'd3, 2'd3, 16'd60}
	};
	string test_name [NUM_TESTS] = '{
		"warmup_idle", "warmup_gaps", "link_up_run", "valid_gaps", "enable_gaps",
		"bad_headers", "rf_bypass", "bypass_gaps", "link_drop", "relink_random"
	};

	logic    clock = 1'b0;
	logic    reset;
	logic    valid;
	logic    enable;
	logic    link_up;
	logic    rf_bypass;
	block_t  data;
	tagged_t out_data;
	logic    out_valid;
	logic    out_link_active;
	int      check_count;
	int      error_count;
	integer  seed;
	int      cycle_limit = 0;
	int      cycle_count = 0;

	always #20 clock = ~clock;

	tx_lane_top tx_lane_top_i
	(
		.i_clock       (clock),
		.i_reset       (reset),
		.i_valid       (valid),
		.i_enable      (enable),
		.i_link_up     (link_up),
		.i_rf_bypass   (rf_bypass),
		.i_data        (data),
		.o_data        (out_data),
		.o_valid       (out_valid),
		.o_link_active (out_link_active)
	);

	tx_lane_checker tx_lane_checker_i
	(
		.i_clock           (clock),
		.i_reset           (reset),
		.i_valid           (valid),
		.i_enable          (enable),
		.i_link_up         (link_up),
		.i_rf_bypass       (rf_bypass),
		.i_data            (data),
		.i_out_data        (out_data),
		.i_out_valid       (out_valid),
		.i_out_link_active (out_link_active),
		.o_check_count     (check_count),
		.o_error_count     (error_count)
	);

	bind tx_lane_top tx_lane_asserts tx_lane_asserts_i
	(
		.i_clock           (i_clock),
		.i_reset           (i_reset),
		.i_out_valid       (o_valid),
		.i_out_data        (o_data),
		.i_out_link_active (o_link_active)
	);

	function automatic int total_blocks();
		int sum;
		sum = 0;
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			sum += int'(test_table[t].block_count);
		end
		return sum;
	endfunction

	task automatic drive_block(input test_row_t row, input int n);
		logic [31:0] strobe_word;
		logic [31:0] word_hi;
		logic [31:0] word_lo;
		strobe_word = $random(seed);
		word_hi     = $random(seed);
		word_lo     = $random(seed);
		link_up     = row.link_up;
		rf_bypass   = row.rf_bypass;
		valid       = (row.strobe_sel == 2'd3) ? strobe_word[0]
			: (row.strobe_sel != 2'd1 || n % 3 != 2);
		enable      = (row.strobe_sel == 2'd3) ? strobe_word[1]
			: (row.strobe_sel != 2'd2 || n % 2 == 0);
		case (row.header_sel)
			2'd0: data.sync_header = 2'b01;
			2'd1: data.sync_header = 2'b10;
			2'd2: data.sync_header = strobe_word[2] ? 2'b10 : 2'b01;
			default: data.sync_header = strobe_word[4:3];   // 00 and 11 show up here
		endcase
		data.payload = {word_hi, word_lo};
	endtask

	initial
	begin
		@(posedge clock);
		while (cycle_count < cycle_limit)
		begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: the test table did not finish within %0d cycles", cycle_limit);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		int checks_before;
		int errors_before;
		int bad_tests;
		seed        = 36464;
		reset       = 1'b1;
		valid       = 1'b0;
		enable      = 1'b0;
		link_up     = 1'b0;
		rf_bypass   = 1'b0;
		data        = '0;
		bad_tests   = 0;
		cycle_limit = 2 * total_blocks() + 50;
		repeat (8) @(posedge clock);
		checks_before = check_count;
		errors_before = error_count;
		@(negedge clock);
		reset = 1'b0;
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			for (int n = 0; n < int'(test_table[t].block_count); n++)
			begin
				drive_block(test_table[t], n);
				@(negedge clock);
			end
			valid  = 1'b0;
			enable = 1'b0;
			@(posedge clock);   // last block has been compared by now
			if (error_count != errors_before)
			begin
				bad_tests++;
			end
			$display("test %0d %s done, %0d checks, %0d mismatches", t, test_name[t],
				check_count - checks_before, error_count - errors_before);
			checks_before = check_count;
			errors_before = error_count;
			@(negedge clock);
		end
		@(posedge clock);
		$display("tests %0d, tests with mismatches %0d, checks %0d, mismatches %0d",
			NUM_TESTS, bad_tests, check_count, error_count);
		if (error_count == 0 && check_count > 0)
		begin
			$display("Simulation completed successfully");
		end
		else
		begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/tx_lane_asserts.sv
`default_nettype none

module tx_lane_asserts
(
	input logic                 i_clock,
	input logic                 i_reset,
	input logic                 i_out_valid,
	input tx_lane_pkg::tagged_t i_out_data,
	input logic                 i_out_link_active
);

	timeunit 1ns;
	timeprecision 1ps;

	// covers every reset cycle and the first cycle after it
	valid_low_after_reset: assert property (@(posedge i_clock) i_reset |=> !i_out_valid)
		else $error("o_valid was high during reset or on the cycle after it");

	// tagged slot blocks go out raw, everything else carries a legal header
	header_legal: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_out_valid && !i_out_data.tag) |-> (i_out_data.block.sync_header inside {2'b01, 2'b10}))
		else $error("an untagged output block carried a sync header of 00 or 11");

	tag_needs_link: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_out_valid && i_out_data.tag) |-> i_out_link_active)
		else $error("the tag bit was set while the link was not active");

endmodule

`default_nettype wire

//--- bench/tx_lane_checker.sv
`default_nettype none
`include "tx_lane_cfg.svh"

module tx_lane_checker
(
	input  logic                 i_clock,
	input  logic                 i_reset,
	input  logic                 i_valid,
	input  logic                 i_enable,
	input  logic                 i_link_up,
	input  logic                 i_rf_bypass,
	input  tx_lane_pkg::block_t  i_data,
	input  tx_lane_pkg::tagged_t i_out_data,
	input  logic                 i_out_valid,
	input  logic                 i_out_link_active,
	output int                   o_check_count,
	output int                   o_error_count
);

	timeunit 1ns;
	timeprecision 1ps;

	import tx_lane_pkg::*;

	localparam int POLY_HI  = 58;   // x^58 term, the bit sent 58 bits back
	localparam int POLY_MID = 39;   // x^39 term
	localparam block_t IDLE = `TX_IDLE_BLOCK;

	logic [POLY_HI:1] history;   // history[k] is the scrambled bit sent k bits ago
	int               block_index;
	logic             link_run;
	logic             exp_ready = 1'b0;
	logic             exp_reset;
	logic             exp_valid;
	tagged_t          exp_data;
	logic             exp_active;
	int               checks = 0;
	int               errors = 0;

	assign o_check_count = checks;
	assign o_error_count = errors;

	// out(n) = in(n) ^ out(n-39) ^ out(n-58), sent msb first
	task automatic scramble_payload(input logic [63:0] plain, output logic [63:0] coded);
		logic bit_out;
		coded = '0;
		for (int n = 63; n >= 0; n--)
		begin
			bit_out  = plain[n] ^ history[POLY_MID] ^ history[POLY_HI];
			coded[n] = bit_out;
			history  = {history[POLY_HI-1:1], bit_out};
		end
	endtask

	task automatic compare_value(input string name, input logic [66:0] expected,
		input logic [66:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("FAIL time=%0t signal=%s expected=%h actual=%h", $time, name, expected,
				actual);
		end
	endtask

	// expected response of the block sampled at this edge
	always @(posedge i_clock)
	begin
		logic      accept;
		logic      slot;
		block_t    sent;
		blk_mode_t mode;
		exp_ready = 1'b1;
		if (i_reset)
		begin
			history     = '1;
			block_index = 0;
			link_run    = 1'b0;
			exp_reset   = 1'b1;
			exp_valid   = 1'b0;
			exp_data    = '0;
			exp_active  = 1'b0;
		end
		else
		begin
			accept    = i_valid && i_enable;
			exp_reset = 1'b0;
			exp_valid = accept;
			if (accept)
			begin
				slot = ((block_index % `TX_AM_PERIOD) == `TX_AM_PERIOD - 1);
				block_index++;
				// an accepted block runs exactly when link-up is high during it
				if (!i_link_up)
				begin
					mode = MODE_IDLE;
				end
				else if (slot || i_rf_bypass)
				begin
					mode = MODE_BYPASS_TAG;
				end
				else if (i_data.sync_header inside {2'b00, 2'b11})
				begin
					mode = MODE_IDLE;
				end
				else
				begin
					mode = MODE_SCRAMBLE;
				end
				case (mode)
					MODE_BYPASS_TAG:
					begin
						sent = i_data;   // raw, history untouched
					end
					MODE_IDLE:
					begin
						sent.sync_header = IDLE.sync_header;
						scramble_payload(IDLE.payload, sent.payload);
					end
					default:
					begin
						sent.sync_header = i_data.sync_header;
						scramble_payload(i_data.payload, sent.payload);
					end
				endcase
				exp_data.tag   = i_link_up && slot;
				exp_data.block = sent;
				if (i_link_up)
				begin
					link_run = 1'b1;
				end
			end
			if (!i_link_up)
			begin
				link_run = 1'b0;
			end
			exp_active = link_run;
		end
	end

	// outputs have settled half a cycle after the edge
	always @(negedge i_clock)
	begin
		if (exp_ready)
		begin
			compare_value("o_valid", 67'(exp_valid), 67'(i_out_valid));
			compare_value("o_link_active", 67'(exp_active), 67'(i_out_link_active));
			if (exp_valid || exp_reset)
			begin
				compare_value("o_data", exp_data, i_out_data);
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/am_period_timer.sv
`default_nettype none
`include "tx_lane_cfg.svh"

module am_period_timer
(
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_accept,
	output logic o_am_slot
);

	localparam int CNT_W = (`TX_AM_PERIOD > 1) ? $clog2(`TX_AM_PERIOD) : 1;
	localparam logic [CNT_W-1:0] LAST_BLOCK = CNT_W'(`TX_AM_PERIOD - 1);

	logic [CNT_W-1:0] block_count;
	logic             last_block;

	assign last_block = (block_count == LAST_BLOCK);

	// only the accepted block itself is flagged, idle cycles in between are not
	assign o_am_slot = i_accept && last_block;

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			block_count <= '0;
		end
		else if (i_accept)
		begin
			if (last_block)
			begin
				block_count <= '0;   // wrap right after the slot block
			end
			else
			begin
				block_count <= block_count + CNT_W'(1);
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/scrambler.sv
`default_nettype none
`include "tx_lane_cfg.svh"

module scrambler
(
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_accept,
	input  logic                   i_tag,
	input  tx_lane_pkg::blk_mode_t i_mode,
	input  tx_lane_pkg::block_t    i_data,
	output tx_lane_pkg::tagged_t   o_data,
	output logic                   o_valid
);

	import tx_lane_pkg::*;

	localparam block_t IDLE_BLOCK = `TX_IDLE_BLOCK;

	logic [`TX_NB_SCRAMBLER-1:0] state;
	logic [`TX_NB_SCRAMBLER-1:0] state_next;
	logic [`TX_NB_PAYLOAD-1:0]   scrambled_payload;
	logic                        out_bit;
	block_t                      source_block;
	block_t                      coded_block;
	logic                        advance;

	// idle mode scrambles the idle block in place of the input, its header is 10
	assign source_block = (i_mode == MODE_IDLE) ? IDLE_BLOCK : i_data;

	// state only moves when a scrambled block is actually sent
	assign advance = i_accept && (i_mode != MODE_BYPASS_TAG);

	// msb first, each output bit is fed back into the top of the state
	always_comb
	begin
		state_next        = state;
		scrambled_payload = '0;
		out_bit           = 1'b0;
		for (int i = `TX_NB_PAYLOAD - 1; i >= 0; i--)
		begin
			out_bit = source_block.payload[i] ^ state_next[`TX_TAP_A] ^ state_next[`TX_TAP_B];
			scrambled_payload[i] = out_bit;
			state_next = {out_bit, state_next[`TX_NB_SCRAMBLER-1:1]};
		end
	end

	always_comb
	begin
		if (i_mode == MODE_BYPASS_TAG)
		begin
			coded_block = i_data;   // raw block, alignment slot or external bypass
		end
		else
		begin
			coded_block.sync_header = source_block.sync_header;
			coded_block.payload     = scrambled_payload;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state <= `TX_SEED;
		end
		else if (advance)
		begin
			state <= state_next;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_valid <= 1'b0;
			o_data  <= '0;
		end
		else
		begin
			o_valid <= i_accept;
			if (i_accept)
			begin
				o_data.tag   <= i_tag;
				o_data.block <= coded_block;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/tx_lane_cfg.svh
`ifndef TX_LANE_CFG_SVH
`define TX_LANE_CFG_SVH

// block layout
`define TX_NB_SH        2
`define TX_NB_PAYLOAD   64

// x^58 + x^39 + 1 self-synchronous scrambler
`define TX_NB_SCRAMBLER 58
`define TX_TAP_A        19   // 57 - 38, the x^39 term
`define TX_TAP_B        0    // oldest output bit, the x^58 term

// all ones so the first scrambled blocks are not plain zero
`define TX_SEED         {`TX_NB_SCRAMBLER{1'b1}}

// idle control block, header 10 then the idle control payload
`define TX_IDLE_BLOCK   66'h2_7800_0000_0000_0000

// accepted blocks per alignment slot
`define TX_AM_PERIOD    16

`endif

//--- hdl/tx_lane_ctrl.sv
`default_nettype none

module tx_lane_ctrl
(
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_accept,
	input  logic                   i_link_up,
	input  logic                   i_rf_bypass,
	input  logic                   i_am_slot,
	input  logic [1:0]             i_sync_header,
	output tx_lane_pkg::blk_mode_t o_mode,
	output logic                   o_tag,
	output logic                   o_link_active
);

	import tx_lane_pkg::*;

	tx_state_t state;
	tx_state_t state_next;
	logic      run_block;
	logic      header_ok;

	assign header_ok = i_sync_header[1] ^ i_sync_header[0];   // only 01 and 10 are legal

	// the accepted block that first sees link-up is already handled as a run block
	assign run_block = i_link_up && ((state == ST_RUN) || i_accept);

	always_comb
	begin
		state_next = state;
		case (state)
			ST_WARMUP:
			begin
				if (i_accept && i_link_up)
				begin
					state_next = ST_RUN;
				end
			end
			ST_RUN:
			begin
				if (!i_link_up)
				begin
					state_next = ST_WARMUP;   // any drop of the link restarts warm-up
				end
			end
			default:
			begin
				state_next = ST_WARMUP;
			end
		endcase
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state <= ST_WARMUP;
		end
		else
		begin
			state <= state_next;
		end
	end

	// warm-up first, then slot or bypass, then header check
	always_comb
	begin
		if (!run_block)
		begin
			o_mode = MODE_IDLE;
		end
		else if (i_am_slot || i_rf_bypass)
		begin
			o_mode = MODE_BYPASS_TAG;
		end
		else if (!header_ok)
		begin
			o_mode = MODE_IDLE;   // a broken header never reaches the line
		end
		else
		begin
			o_mode = MODE_SCRAMBLE;
		end
	end

	assign o_tag         = run_block && i_am_slot;
	assign o_link_active = (state == ST_RUN);

endmodule

`default_nettype wire

//--- hdl/tx_lane_pkg.sv
`default_nettype none
`include "tx_lane_cfg.svh"

package tx_lane_pkg;

	// coded block as it leaves the encoder
	typedef struct packed
	{
		logic [`TX_NB_SH-1:0]      sync_header;   // bits 65:64
		logic [`TX_NB_PAYLOAD-1:0] payload;       // bits 63:0
	} block_t;

	// block as handed to the gearbox, tag on top
	typedef struct packed
	{
		logic   tag;     // bit 66, marks an alignment slot
		block_t block;   // bits 65:0
	} tagged_t;

	typedef enum logic
	{
		ST_WARMUP = 1'b0,   // sending idle until the link comes up
		ST_RUN    = 1'b1
	} tx_state_t;

	// treatment chosen for the block in flight
	typedef enum logic [1:0]
	{
		MODE_SCRAMBLE   = 2'd0,
		MODE_IDLE       = 2'd1,
		MODE_BYPASS_TAG = 2'd2
	} blk_mode_t;

endpackage

`default_nettype wire

//--- hdl/tx_lane_top.sv
`default_nettype none

module tx_lane_top
(
	input  logic                 i_clock,
	input  logic                 i_reset,
	input  logic                 i_valid,
	input  logic                 i_enable,
	input  logic                 i_link_up,
	input  logic                 i_rf_bypass,
	input  tx_lane_pkg::block_t  i_data,
	output tx_lane_pkg::tagged_t o_data,
	output logic                 o_valid,
	output logic                 o_link_active
);

	import tx_lane_pkg::*;

	logic      accept;
	logic      am_slot;
	logic      block_tag;
	blk_mode_t block_mode;

	// no back-pressure, a block is taken whenever both strobes are high
	assign accept = i_valid && i_enable;

	am_period_timer am_period_timer_i
	(
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_accept  (accept),
		.o_am_slot (am_slot)
	);

	// mode and tag settle in the same cycle as the block they apply to
	tx_lane_ctrl tx_lane_ctrl_i
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_accept      (accept),
		.i_link_up     (i_link_up),
		.i_rf_bypass   (i_rf_bypass),
		.i_am_slot     (am_slot),
		.i_sync_header (i_data.sync_header),
		.o_mode        (block_mode),
		.o_tag         (block_tag),
		.o_link_active (o_link_active)
	);

	scrambler scrambler_i
	(
		.i_clock  (i_clock),
		.i_reset  (i_reset),
		.i_accept (accept),
		.i_tag    (block_tag),
		.i_mode   (block_mode),
		.i_data   (i_data),
		.o_data   (o_data),
		.o_valid  (o_valid)
	);

endmodule

`default_nettype wire

//--- tx_lane.f
+incdir+hdl
hdl/tx_lane_pkg.sv
hdl/am_period_timer.sv
hdl/tx_lane_ctrl.sv
hdl/scrambler.sv
hdl/tx_lane_top.sv
bench/tx_lane_checker.sv
bench/tx_lane_asserts.sv
bench/tb_tx_lane.sv
